//--- include/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath width of the integer pipeline
`define EXEC_XLEN 32

// shifts use only this many low bits of src_b
`define EXEC_SHAMT_W 5

// one quotient bit per iteration
`define EXEC_DIV_STEPS 32

`endif

//--- rtl/isa_pkg.sv
`include "exec_config.svh"

package isa_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;

    // operation select as issued by decode
    typedef enum logic [5:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,
        SUB   = 6'd2,
        SLT   = 6'd3,
        SLTU  = 6'd4,
        DIV   = 6'd5,
        DIVU  = 6'd6,
        MULT  = 6'd7,
        MULTU = 6'd8,
        AND   = 6'd9,
        NOR   = 6'd10,
        OR    = 6'd11,
        XOR   = 6'd12,
        SLL   = 6'd13,
        SRA   = 6'd14,
        SRL   = 6'd15,
        LUI   = 6'd16,
        MFHI  = 6'd17,  // read back HI
        MFLO  = 6'd18,
        MTHI  = 6'd19,  // src_a into HI
        MTLO  = 6'd20
    } alu_sel_e;

endpackage

//--- rtl/muldiv_pkg.sv
`include "exec_config.svh"

package muldiv_pkg;

    // HI in the upper half, LO in the lower half
    typedef logic [2*`EXEC_XLEN-1:0] dword_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,  // one shift-subtract step per cycle
        DONE = 2'd2   // result valid, stall released
    } div_state_e;

endpackage

//--- rtl/divider.sv
`include "exec_config.svh"

module divider (
    input  logic           clk,
    input  logic           rst_n,
    input  isa_pkg::word_t src_a,
    input  isa_pkg::word_t src_b,
    input  logic           en,
    input  logic           div_sign,
    output isa_pkg::word_t quot,
    output isa_pkg::word_t rem,
    output logic           res_ready,
    output logic           stall_req
);
    localparam int MSB = `EXEC_XLEN - 1;
    localparam int CNT_W = $clog2(`EXEC_DIV_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EXEC_DIV_STEPS - 1);

    muldiv_pkg::div_state_e state;
    logic [CNT_W-1:0] step_cnt;

    isa_pkg::word_t a_mag;
    isa_pkg::word_t b_mag;
    isa_pkg::word_t q_reg;     // dividend shifts out, quotient shifts in
    isa_pkg::word_t r_reg;     // partial remainder
    isa_pkg::word_t d_reg;     // divisor magnitude
    logic neg_quot;
    logic neg_rem;
    logic div_zero;

    logic [`EXEC_XLEN:0]   r_shift;
    logic [`EXEC_XLEN+1:0] trial;

    always_comb begin
        a_mag   = (div_sign && src_a[MSB]) ? -src_a : src_a;
        b_mag   = (div_sign && src_b[MSB]) ? -src_b : src_b;
        r_shift = {r_reg, q_reg[MSB]};
        trial   = {1'b0, r_shift} - {2'b00, d_reg};  // msb set means restore
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= muldiv_pkg::IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                muldiv_pkg::IDLE: begin
                    step_cnt <= '0;
                    if (en)
                        state <= muldiv_pkg::RUN;
                end
                muldiv_pkg::RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_STEP)
                        state <= muldiv_pkg::DONE;
                end
                muldiv_pkg::DONE: state <= muldiv_pkg::IDLE;
                default:          state <= muldiv_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == muldiv_pkg::IDLE && en) begin
            q_reg    <= a_mag;
            r_reg    <= '0;
            d_reg    <= b_mag;
            neg_quot <= div_sign && (src_a[MSB] ^ src_b[MSB]);
            neg_rem  <= div_sign && src_a[MSB];
            div_zero <= (src_b == '0);
        end else if (state == muldiv_pkg::RUN) begin
            if (!trial[`EXEC_XLEN+1]) begin
                r_reg <= trial[MSB:0];
                q_reg <= {q_reg[MSB-1:0], 1'b1};
            end else begin
                r_reg <= r_shift[MSB:0];
                q_reg <= {q_reg[MSB-1:0], 1'b0};
            end
        end
    end

    // with a zero divisor r_reg ends up holding the dividend magnitude
    assign quot = div_zero ? '1 : (neg_quot ? -q_reg : q_reg);
    assign rem  = neg_rem ? -r_reg : r_reg;

    assign res_ready = (state == muldiv_pkg::DONE);
    assign stall_req = (state == muldiv_pkg::IDLE && en) || (state == muldiv_pkg::RUN);

endmodule

//--- rtl/alu.sv
`include "exec_config.svh"

module alu (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    src_a,
    input  isa_pkg::word_t    src_b,
    input  isa_pkg::alu_sel_e alu_sel,
    output isa_pkg::word_t    alu_res,
    output isa_pkg::word_t    alu_hi_res,
    output isa_pkg::word_t    alu_lo_res,
    output logic [1:0]        hilo_we,    // [1] HI, [0] LO
    output logic              stall_req
);
    logic [`EXEC_SHAMT_W-1:0] shamt;
    muldiv_pkg::dword_t s_prod;
    muldiv_pkg::dword_t u_prod;

    logic           div_en;
    logic           div_sign;
    isa_pkg::word_t quot;
    isa_pkg::word_t rem;
    logic           res_ready;

    assign shamt  = src_b[`EXEC_SHAMT_W-1:0];
    assign s_prod = $signed(src_a) * $signed(src_b);
    assign u_prod = src_a * src_b;

    divider i_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_a     (src_a),
        .src_b     (src_b),
        .en        (div_en),
        .div_sign  (div_sign),
        .quot      (quot),
        .rem       (rem),
        .res_ready (res_ready),
        .stall_req (stall_req)
    );

    always_comb begin
        alu_res    = '0;
        alu_hi_res = '0;
        alu_lo_res = '0;
        hilo_we    = 2'b00;
        div_en     = 1'b0;
        div_sign   = 1'b0;

        case (alu_sel)
            isa_pkg::ADD:  alu_res = src_a + src_b;  // no overflow trap
            isa_pkg::SUB:  alu_res = src_a - src_b;
            isa_pkg::SLT:  alu_res = isa_pkg::word_t'($signed(src_a) < $signed(src_b));
            isa_pkg::SLTU: alu_res = isa_pkg::word_t'(src_a < src_b);
            isa_pkg::AND:  alu_res = src_a & src_b;
            isa_pkg::NOR:  alu_res = ~(src_a | src_b);
            isa_pkg::OR:   alu_res = src_a | src_b;
            isa_pkg::XOR:  alu_res = src_a ^ src_b;
            isa_pkg::SLL:  alu_res = src_a << shamt;
            isa_pkg::SRA:  alu_res = $signed(src_a) >>> shamt;
            isa_pkg::SRL:  alu_res = src_a >> shamt;
            isa_pkg::LUI:  alu_res = src_b << 16;
            isa_pkg::DIV, isa_pkg::DIVU: begin
                div_en   = 1'b1;
                div_sign = (alu_sel == isa_pkg::DIV);
                if (res_ready) begin
                    alu_hi_res = rem;
                    alu_lo_res = quot;
                    hilo_we    = 2'b11;
                end
            end
            isa_pkg::MULT: begin
                {alu_hi_res, alu_lo_res} = s_prod;
                hilo_we = 2'b11;
            end
            isa_pkg::MULTU: begin
                {alu_hi_res, alu_lo_res} = u_prod;
                hilo_we = 2'b11;
            end
            isa_pkg::MTHI: begin
                alu_hi_res = src_a;
                hilo_we    = 2'b10;
            end
            isa_pkg::MTLO: begin
                alu_lo_res = src_a;
                hilo_we    = 2'b01;
            end
            default: alu_res = '0;  // NOP and move-from, result picked in hilo_unit
        endcase
    end

endmodule

//--- rtl/hilo_unit.sv
module hilo_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::alu_sel_e alu_sel,
    input  isa_pkg::word_t    alu_res,
    input  isa_pkg::word_t    alu_hi_res,
    input  isa_pkg::word_t    alu_lo_res,
    input  logic [1:0]        hilo_we,
    output isa_pkg::word_t    exec_res,
    output isa_pkg::word_t    hi,
    output isa_pkg::word_t    lo
);
    isa_pkg::word_t hi_q;
    isa_pkg::word_t lo_q;

    // architectural registers, cleared so reads after reset are defined
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hilo_we[1])
                hi_q <= alu_hi_res;
            if (hilo_we[0])
                lo_q <= alu_lo_res;
        end
    end

    // move-from sees the value before this edge
    always_comb begin
        case (alu_sel)
            isa_pkg::MFHI: exec_res = hi_q;
            isa_pkg::MFLO: exec_res = lo_q;
            default:       exec_res = alu_res;
        endcase
    end

    assign hi = hi_q;
    assign lo = lo_q;

endmodule

//--- rtl/exec_unit.sv
module exec_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    src_a,
    input  isa_pkg::word_t    src_b,
    input  isa_pkg::alu_sel_e alu_sel,
    output isa_pkg::word_t    exec_res,
    output isa_pkg::word_t    hi,
    output isa_pkg::word_t    lo,
    output logic              stall_req
);
    isa_pkg::word_t alu_res;
    isa_pkg::word_t alu_hi_res;
    isa_pkg::word_t alu_lo_res;
    logic [1:0]     hilo_we;

    alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_sel    (alu_sel),
        .alu_res    (alu_res),
        .alu_hi_res (alu_hi_res),
        .alu_lo_res (alu_lo_res),
        .hilo_we    (hilo_we),
        .stall_req  (stall_req)   // held high while a divide runs
    );

    hilo_unit i_hilo_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_sel    (alu_sel),
        .alu_res    (alu_res),
        .alu_hi_res (alu_hi_res),
        .alu_lo_res (alu_lo_res),
        .hilo_we    (hilo_we),
        .exec_res   (exec_res),
        .hi         (hi),
        .lo         (lo)
    );

endmodule

//--- sim/clk_gen.sv
module clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime HALF_PERIOD = 10.0;  // 20 ns period

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- sim/exec_unit_assert.sv
module exec_unit_assert (
    input logic              clk,
    input logic              rst_n,
    input isa_pkg::alu_sel_e alu_sel,
    input isa_pkg::word_t    exec_res,
    input logic              stall_req
);
    timeunit 1ns;
    timeprecision 1ps;

    stall_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall_req)
        else $error("stall_req high in the first cycle after reset");

    // only a divide may hold the pipeline
    stall_only_on_divide: assert property (@(posedge clk) disable iff (!rst_n)
        stall_req |-> (alu_sel == isa_pkg::DIV || alu_sel == isa_pkg::DIVU))
        else $error("stall_req high while a non-divide operation is presented");

    compare_is_boolean: assert property (@(posedge clk) disable iff (!rst_n)
        (alu_sel == isa_pkg::SLT || alu_sel == isa_pkg::SLTU) |-> exec_res <= 32'd1)
        else $error("set-less-than result above 1");

endmodule

bind exec_unit exec_unit_assert i_exec_unit_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_sel   (alu_sel),
    .exec_res  (exec_res),
    .stall_req (stall_req)
);

//--- sim/tb_exec_unit.sv
`include "exec_config.svh"

module tb_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS     = 142;
    localparam int NUM_DIVS    = 14;
    localparam int CYCLE_LIMIT = 40 * NUM_OPS + 34 * NUM_DIVS;

    logic              clk;
    logic              rst_n;
    isa_pkg::word_t    src_a;
    isa_pkg::word_t    src_b;
    isa_pkg::alu_sel_e alu_sel;
    isa_pkg::word_t    exec_res;
    isa_pkg::word_t    hi;
    isa_pkg::word_t    lo;
    logic              stall_req;

    integer seed = 32'h9f18;
    int     cycle_cnt = 0;

    clk_gen i_clk_gen (.clk(clk));

    exec_unit i_exec_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_sel   (alu_sel),
        .exec_res  (exec_res),
        .hi        (hi),
        .lo        (lo),
        .stall_req (stall_req)
    );

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t got,
                              input isa_pkg::word_t want);
        if (got !== want)
            stop_on_failure($sformatf("Error: %s is %h, expected %h", name, got, want));
    endtask

    task automatic check_hilo(input muldiv_pkg::dword_t got, input muldiv_pkg::dword_t want);
        if (got !== want)
            stop_on_failure($sformatf("Error: hi/lo is %h, expected %h", got, want));
    endtask

    function automatic isa_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic isa_pkg::word_t expected_simple(input isa_pkg::alu_sel_e op,
                                                       input isa_pkg::word_t a,
                                                       input isa_pkg::word_t b);
        logic [`EXEC_SHAMT_W-1:0] sh;
        isa_pkg::word_t fill;
        sh   = b[`EXEC_SHAMT_W-1:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // sign bits shifted in by SRA
        case (op)
            isa_pkg::ADD:  return a + b;
            isa_pkg::SUB:  return a + ~b + 32'd1;
            isa_pkg::SLT:  return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            isa_pkg::SLTU: return {31'd0, a < b};
            isa_pkg::AND:  return a & b;
            isa_pkg::OR:   return a | b;
            isa_pkg::NOR:  return ~(a | b);
            isa_pkg::XOR:  return a ^ b;
            isa_pkg::SLL:  return a << sh;
            isa_pkg::SRL:  return a >> sh;
            isa_pkg::SRA:  return (a >> sh) | fill;
            isa_pkg::LUI:  return {b[15:0], 16'h0000};
            default:       return 32'h0;
        endcase
    endfunction

    function automatic muldiv_pkg::dword_t expected_product(input logic sgn,
                                                            input isa_pkg::word_t a,
                                                            input isa_pkg::word_t b);
        muldiv_pkg::dword_t ax;
        muldiv_pkg::dword_t bx;
        ax = sgn ? {{32{a[31]}}, a} : {32'h0, a};
        bx = sgn ? {{32{b[31]}}, b} : {32'h0, b};
        return ax * bx;  // low 64 bits of the extended product
    endfunction

    // {remainder, quotient} as they land in HI and LO
    function automatic muldiv_pkg::dword_t expected_divide(input logic sgn,
                                                           input isa_pkg::word_t a,
                                                           input isa_pkg::word_t b);
        isa_pkg::word_t am;
        isa_pkg::word_t bm;
        isa_pkg::word_t q;
        isa_pkg::word_t r;
        if (b == 32'h0)
            return {a, 32'hffff_ffff};
        am = (sgn && a[31]) ? ~a + 32'd1 : a;
        bm = (sgn && b[31]) ? ~b + 32'd1 : b;
        q  = am / bm;
        r  = am % bm;
        if (sgn && (a[31] != b[31]))
            q = ~q + 32'd1;
        if (sgn && a[31])
            r = ~r + 32'd1;
        return {r, q};
    endfunction

    task automatic present_op(input isa_pkg::alu_sel_e op, input isa_pkg::word_t a,
                              input isa_pkg::word_t b);
        @(posedge clk);
        #2;
        alu_sel = op;
        src_a   = a;
        src_b   = b;
        @(negedge clk);  // outputs settled
    endtask

    task automatic check_simple_op(input isa_pkg::alu_sel_e op, input isa_pkg::word_t a,
                                   input isa_pkg::word_t b);
        present_op(op, a, b);
        check_word("exec_res", exec_res, expected_simple(op, a, b));
    endtask

    task automatic run_divide(input isa_pkg::alu_sel_e op, input isa_pkg::word_t a,
                              input isa_pkg::word_t b);
        muldiv_pkg::dword_t want;
        int                 stalled;
        want    = expected_divide(op == isa_pkg::DIV, a, b);
        stalled = 0;
        present_op(op, a, b);
        if (!stall_req)
            stop_on_failure("divide was presented but stall_req stayed low");
        while (stall_req) begin
            stalled++;
            @(negedge clk);
        end
        // first cycle plus the RUN steps, DONE drops the stall
        if (stalled != `EXEC_DIV_STEPS + 1)
            stop_on_failure($sformatf("Error: stall_req cycles is %0h, expected %0h",
                                      stalled, `EXEC_DIV_STEPS + 1));
        present_op(isa_pkg::NOP, 32'h0, 32'h0);  // HI/LO written at the edge closing DONE
        check_hilo({hi, lo}, want);
    endtask

    task automatic test_arith();
        isa_pkg::word_t    edges [4];
        isa_pkg::alu_sel_e ops [4];
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        edges = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h7fff_ffff};
        ops   = '{isa_pkg::ADD, isa_pkg::SUB, isa_pkg::SLT, isa_pkg::SLTU};
        for (int k = 0; k < 10; k++) begin
            a = (k < 4) ? edges[k] : rand_word();
            b = (k < 4) ? edges[(k + 1) % 4] : rand_word();
            foreach (ops[i])
                check_simple_op(ops[i], a, b);
        end
    endtask

    task automatic test_logic();
        isa_pkg::alu_sel_e ops [8];
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        ops = '{isa_pkg::AND, isa_pkg::OR, isa_pkg::NOR, isa_pkg::XOR,
                isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::LUI};
        for (int k = 0; k < 5; k++) begin
            a = (k == 0) ? 32'h8000_00f1 : rand_word();
            b = (k == 0) ? 32'h0000_0025 : rand_word();  // 37, only 5 counts
            foreach (ops[i])
                check_simple_op(ops[i], a, b);
        end
    endtask

    task automatic test_multiply();
        muldiv_pkg::dword_t prod;
        isa_pkg::word_t     a;
        isa_pkg::word_t     b;
        for (int k = 0; k < 8; k++) begin
            a = (k < 2) ? 32'h8000_0000 : rand_word();
            b = (k < 2) ? 32'hffff_ffff : rand_word();
            prod = expected_product(k[0] == 1'b0, a, b);
            if (k[0])
                present_op(isa_pkg::MULTU, a, b);
            else
                present_op(isa_pkg::MULT, a, b);
            present_op(isa_pkg::MFHI, 32'h0, 32'h0);
            check_hilo({hi, lo}, prod);
            check_word("exec_res", exec_res, prod[63:32]);
            present_op(isa_pkg::MFLO, 32'h0, 32'h0);
            check_word("exec_res", exec_res, prod[31:0]);
        end
    endtask

    task automatic test_divide();
        isa_pkg::word_t dividends [4];
        isa_pkg::word_t divisors [4];
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        dividends = '{32'hffff_ff9c, 32'h0000_0064, 32'h8000_0000, 32'hffff_ff9c};
        divisors  = '{32'h0000_0007, 32'hffff_fff9, 32'hffff_ffff, 32'hffff_fff9};
        for (int k = 0; k < 6; k++) begin
            a = (k < 4) ? dividends[k] : rand_word();
            b = (k < 4) ? divisors[k] : (rand_word() >> 12);
            run_divide(isa_pkg::DIV, a, b);
            run_divide(isa_pkg::DIVU, a, b);
        end
    endtask

    task automatic test_zero_and_moves();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        run_divide(isa_pkg::DIV, 32'hffff_ff9c, 32'h0);
        run_divide(isa_pkg::DIVU, rand_word(), 32'h0);
        for (int k = 0; k < 2; k++) begin
            a = rand_word();
            b = rand_word();
            present_op(isa_pkg::MTHI, a, 32'h0);
            present_op(isa_pkg::MTLO, b, 32'h0);
            present_op(isa_pkg::MFHI, 32'h0, 32'h0);
            check_word("exec_res", exec_res, a);
            check_hilo({hi, lo}, {a, b});
            present_op(isa_pkg::MFLO, 32'h0, 32'h0);
            check_word("exec_res", exec_res, b);
            present_op(isa_pkg::NOP, rand_word(), rand_word());
            check_hilo({hi, lo}, {a, b});  // NOP must not touch HI/LO
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            stop_on_failure($sformatf("timeout: run did not finish in %0d cycles",
                                      CYCLE_LIMIT));
    end

    initial begin
        rst_n   = 1'b0;
        src_a   = 32'h0;
        src_b   = 32'h0;
        alu_sel = isa_pkg::NOP;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_arith();
        test_logic();
        test_multiply();
        test_divide();
        test_zero_and_moves();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- exec_unit.f
+incdir+include
rtl/isa_pkg.sv
rtl/muldiv_pkg.sv
rtl/divider.sv
rtl/alu.sv
rtl/hilo_unit.sv
rtl/exec_unit.sv
sim/clk_gen.sv
sim/exec_unit_assert.sv
sim/tb_exec_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f exec_unit.f \
    --top-module tb_exec_unit \
    && ./obj_dir/Vtb_exec_unit 2>&1 | tee sim.log
grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
